//--- mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    // Width of a data word and of every operand.
    localparam int xlen = 32;

    // Operation presented by the core. Anything outside the M extension
    // is reduced to md_none before it reaches this unit.
    typedef enum logic [3:0] {
        md_none,
        md_mul,
        md_mulh,
        md_mulhsu,
        md_mulhu,
        md_div,
        md_divu,
        md_rem,
        md_remu
    } md_op_e;

    // Sequencer of the signed divide path.
    // d_init loads the magnitudes into the shift registers.
    // d_calc runs the shift-subtract steps.
    // d_sign restores the signs of quotient and remainder.
    typedef enum logic [1:0] {
        d_idle,
        d_init,
        d_calc,
        d_sign
    } div_state_e;

endpackage

`default_nettype wire

//--- md_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// Request side of one arithmetic block. The top level drives operands and
// operation, and the block answers with hold while it is working.
interface md_req_if;

    logic [mdu_pkg::xlen-1:0] operand_a;
    logic [mdu_pkg::xlen-1:0] operand_b;
    mdu_pkg::md_op_e          op;
    logic                     hold;

    modport ctrl (
        output operand_a,
        output operand_b,
        output op,
        input  hold
    );

    modport unit (
        input  operand_a,
        input  operand_b,
        input  op,
        output hold
    );

endinterface

`default_nettype wire

//--- div.sv
`timescale 1ns/1ns
`default_nettype none

module div (
    input  logic                     clk,
    input  logic                     reset,

    md_req_if.unit                   bus,

    output logic [mdu_pkg::xlen-1:0] div_result_o,
    output logic [mdu_pkg::xlen-1:0] divu_result_o,
    output logic [mdu_pkg::xlen-1:0] rem_result_o,
    output logic [mdu_pkg::xlen-1:0] remu_result_o
);

    logic        sig_op, unsig_op;
    logic        divide_by_zero, divide_by_one, overflow;
    logic        start_u, busy_u, done_u;
    logic        start_s, busy_s, done_s;

    logic [4:0]  cnt_u;
    logic [32:0] rem_u;
    logic [31:0] quo_u;
    logic [31:0] divisor_u;
    logic [33:0] step_u;

    mdu_pkg::div_state_e state_s;
    logic [4:0]  cnt_s;
    logic        a_neg, q_neg;
    logic [31:0] mag_a, mag_b;
    logic [31:0] rem_s;
    logic [30:0] quo_s;
    logic [33:0] step_s;
    logic [31:0] div_q, rem_q;

    // One restoring step. The low bit of the return value is the new
    // quotient bit and the upper bits are the new partial remainder.
    function automatic logic [33:0] div_step(
        input logic [32:0] rem,
        input logic        next_bit,
        input logic [31:0] dvs
    );
        logic [32:0] trial;
        trial = {rem[31:0], next_bit};
        if (trial >= {1'b0, dvs}) begin
            return {trial - {1'b0, dvs}, 1'b1};
        end
        return {trial, 1'b0};
    endfunction

    assign sig_op   = bus.op inside {mdu_pkg::md_div, mdu_pkg::md_rem};
    assign unsig_op = bus.op inside {mdu_pkg::md_divu, mdu_pkg::md_remu};

    assign divide_by_zero = bus.operand_b == 32'h0000_0000;
    assign divide_by_one  = bus.operand_b == 32'h0000_0001;
    assign overflow       = bus.operand_a == 32'h8000_0000 && bus.operand_b == 32'hffff_ffff;

    assign start_u = unsig_op && !busy_u && !done_u;
    assign start_s = sig_op && !busy_s && !done_s;

    assign bus.hold = start_u || busy_u || start_s || busy_s;

    // The special cases finish in the start cycle, so their answers come
    // straight from the operands, which the core keeps steady.
    always_comb begin
        if (divide_by_zero) begin
            divu_result_o = 32'hffff_ffff;
            remu_result_o = bus.operand_a;
        end else if (divide_by_one) begin
            divu_result_o = bus.operand_a;
            remu_result_o = '0;
        end else begin
            divu_result_o = quo_u;
            remu_result_o = rem_u[31:0];
        end
    end

    always_comb begin
        if (divide_by_zero) begin
            div_result_o = 32'hffff_ffff;
            rem_result_o = bus.operand_a;
        end else if (divide_by_one || overflow) begin
            div_result_o = bus.operand_a;
            rem_result_o = '0;
        end else begin
            div_result_o = div_q;
            rem_result_o = rem_q;
        end
    end

    // Unsigned path. Thirty-two steps run on the cycles after the start.
    assign step_u = div_step(rem_u, quo_u[31], divisor_u);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_u <= 1'b0;
            done_u <= 1'b0;
            cnt_u  <= '0;
        end else if (!unsig_op) begin
            done_u <= 1'b0;
        end else if (start_u) begin
            cnt_u <= '0;
            if (divide_by_zero || divide_by_one) begin
                done_u <= 1'b1;
            end else begin
                busy_u    <= 1'b1;
                rem_u     <= '0;
                quo_u     <= bus.operand_a;
                divisor_u <= bus.operand_b;
            end
        end else if (busy_u) begin
            rem_u <= step_u[33:1];
            quo_u <= {quo_u[30:0], step_u[0]};
            cnt_u <= cnt_u + 5'd1;
            if (cnt_u == 5'd31) begin
                busy_u <= 1'b0;
                done_u <= 1'b1;
            end
        end
    end

    // Signed path. The top bit of the dividend magnitude is preloaded into
    // the remainder, since its quotient bit is always zero once the special
    // cases are excluded. That leaves 31 steps.
    assign step_s = div_step({1'b0, rem_s}, quo_s[30], mag_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_s <= mdu_pkg::d_idle;
            busy_s  <= 1'b0;
            done_s  <= 1'b0;
            cnt_s   <= '0;
        end else if (!sig_op) begin
            done_s <= 1'b0;
        end else begin
            case (state_s)
                mdu_pkg::d_init: begin
                    state_s <= mdu_pkg::d_calc;
                    cnt_s   <= '0;
                    rem_s   <= {31'b0, mag_a[31]};
                    quo_s   <= mag_a[30:0];
                end
                mdu_pkg::d_calc: begin
                    rem_s <= step_s[32:1];
                    quo_s <= {quo_s[29:0], step_s[0]};
                    cnt_s <= cnt_s + 5'd1;
                    if (cnt_s == 5'd30) begin
                        state_s <= mdu_pkg::d_sign;
                    end
                end
                mdu_pkg::d_sign: begin
                    state_s <= mdu_pkg::d_idle;
                    busy_s  <= 1'b0;
                    done_s  <= 1'b1;
                    div_q   <= q_neg ? -{1'b0, quo_s} : {1'b0, quo_s};
                    // The remainder follows the sign of the dividend.
                    rem_q   <= a_neg ? -rem_s : rem_s;
                end
                default: begin
                    if (start_s) begin
                        if (divide_by_zero || divide_by_one || overflow) begin
                            done_s <= 1'b1;
                        end else begin
                            state_s <= mdu_pkg::d_init;
                            busy_s  <= 1'b1;
                            a_neg   <= bus.operand_a[31];
                            q_neg   <= bus.operand_a[31] ^ bus.operand_b[31];
                            mag_a   <= bus.operand_a[31] ? -bus.operand_a : bus.operand_a;
                            mag_b   <= bus.operand_b[31] ? -bus.operand_b : bus.operand_b;
                        end
                    end
                end
            endcase
        end
    end

    a_unsig_busy_done: assert property (@(posedge clk) disable iff (reset)
        !(busy_u && done_u));

    a_sig_busy_done: assert property (@(posedge clk) disable iff (reset)
        !(busy_s && done_s));

    // The top level only routes divide operations here, so a stray hold
    // would stall the core for an operation this block does not own.
    a_hold_only_div: assert property (@(posedge clk) disable iff (reset)
        !(sig_op || unsig_op) |-> !bus.hold);

endmodule

`default_nettype wire

//--- mul.sv
`timescale 1ns/1ns
`default_nettype none

module mul (
    input  logic                     clk,
    input  logic                     reset,

    md_req_if.unit                   bus,

    output logic [mdu_pkg::xlen-1:0] mul_result_o
);

    logic               mul_op;
    logic               a_signed, b_signed;
    logic               start, busy, done;
    logic [1:0]         cnt;

    logic [32:0]        ext_a, ext_b;
    logic [32:0]        opa, opb;

    logic signed [16:0] mx, my;
    logic signed [33:0] pp;
    logic signed [65:0] pp_ext;
    logic [65:0]        pp_shifted;
    logic [65:0]        acc;

    assign mul_op = bus.op inside {mdu_pkg::md_mul, mdu_pkg::md_mulh,
                                   mdu_pkg::md_mulhsu, mdu_pkg::md_mulhu};

    assign a_signed = bus.op inside {mdu_pkg::md_mulh, mdu_pkg::md_mulhsu};
    assign b_signed = bus.op == mdu_pkg::md_mulh;

    // Both operands become 33-bit signed values, so one signed product
    // serves every variant.
    assign ext_a = {a_signed & bus.operand_a[31], bus.operand_a};
    assign ext_b = {b_signed & bus.operand_b[31], bus.operand_b};

    assign start    = mul_op && !busy && !done;
    assign bus.hold = start || busy;

    // Each operand is a 17-bit signed high half and a 16-bit low half.
    // The low halves get a zero on top to keep them positive.
    always_comb begin
        case (cnt)
            2'd0: begin
                mx = $signed({1'b0, opa[15:0]});
                my = $signed({1'b0, opb[15:0]});
            end
            2'd1: begin
                mx = $signed({1'b0, opa[15:0]});
                my = $signed(opb[32:16]);
            end
            2'd2: begin
                mx = $signed(opa[32:16]);
                my = $signed({1'b0, opb[15:0]});
            end
            default: begin
                mx = $signed(opa[32:16]);
                my = $signed(opb[32:16]);
            end
        endcase
    end

    assign pp     = mx * my;
    assign pp_ext = pp;

    always_comb begin
        case (cnt)
            2'd0:    pp_shifted = pp_ext;
            2'd3:    pp_shifted = pp_ext <<< 32;
            default: pp_shifted = pp_ext <<< 16;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (!mul_op) begin
            done <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
            opa  <= ext_a;
            opb  <= ext_b;
            acc  <= '0;
        end else if (busy) begin
            acc <= acc + pp_shifted;
            cnt <= cnt + 2'd1;
            if (cnt == 2'd3) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    assign mul_result_o = (bus.op == mdu_pkg::md_mul) ? acc[31:0] : acc[63:32];

    // One start cycle and four partial products bound the stall.
    a_hold_bound: assert property (@(posedge clk) disable iff (reset)
        bus.hold [*5] |=> !bus.hold);

endmodule

`default_nettype wire

//--- mdu.sv
`timescale 1ns/1ns
`default_nettype none

module mdu (
    input  logic                     clk,
    input  logic                     reset,

    input  logic [mdu_pkg::xlen-1:0] first_operand_i,
    input  logic [mdu_pkg::xlen-1:0] second_operand_i,
    input  mdu_pkg::md_op_e          operation_i,

    output logic                     hold_o,
    output logic [mdu_pkg::xlen-1:0] result_o
);

    logic                     is_mul, is_div;
    logic [mdu_pkg::xlen-1:0] div_result, divu_result, rem_result, remu_result;
    logic [mdu_pkg::xlen-1:0] mul_result;

    md_req_if div_bus ();
    md_req_if mul_bus ();

    assign is_mul = operation_i inside {mdu_pkg::md_mul, mdu_pkg::md_mulh,
                                        mdu_pkg::md_mulhsu, mdu_pkg::md_mulhu};
    assign is_div = operation_i inside {mdu_pkg::md_div, mdu_pkg::md_divu,
                                        mdu_pkg::md_rem, mdu_pkg::md_remu};

    // Each block sees only its own operations. That keeps the done flag of
    // the idle block cleared while the other one works.
    assign div_bus.operand_a = first_operand_i;
    assign div_bus.operand_b = second_operand_i;
    assign div_bus.op        = is_div ? operation_i : mdu_pkg::md_none;

    assign mul_bus.operand_a = first_operand_i;
    assign mul_bus.operand_b = second_operand_i;
    assign mul_bus.op        = is_mul ? operation_i : mdu_pkg::md_none;

    div u_div (
        .clk           (clk),
        .reset         (reset),
        .bus           (div_bus),
        .div_result_o  (div_result),
        .divu_result_o (divu_result),
        .rem_result_o  (rem_result),
        .remu_result_o (remu_result)
    );

    mul u_mul (
        .clk          (clk),
        .reset        (reset),
        .bus          (mul_bus),
        .mul_result_o (mul_result)
    );

    assign hold_o = div_bus.hold | mul_bus.hold;

    always_comb begin
        case (operation_i)
            mdu_pkg::md_mul,
            mdu_pkg::md_mulh,
            mdu_pkg::md_mulhsu,
            mdu_pkg::md_mulhu: result_o = mul_result;
            mdu_pkg::md_div:   result_o = div_result;
            mdu_pkg::md_divu:  result_o = divu_result;
            mdu_pkg::md_rem:   result_o = rem_result;
            mdu_pkg::md_remu:  result_o = remu_result;
            default:           result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- tb_mdu_model.svh
`ifndef TB_MDU_MODEL_SVH
`define TB_MDU_MODEL_SVH

// Reference results for the RV32M operations, formed with 64-bit arithmetic.
function automatic logic [31:0] product_word(
    input mdu_pkg::md_op_e op,
    input logic [31:0]     a,
    input logic [31:0]     b
);
    logic signed [63:0] sa, sb, zb;
    logic [63:0]        prod;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    zb = {32'b0, b};
    case (op)
        mdu_pkg::md_mulh:   prod = sa * sb;
        mdu_pkg::md_mulhsu: prod = sa * zb;
        default:            prod = {32'b0, a} * {32'b0, b};
    endcase
    return (op == mdu_pkg::md_mul) ? prod[31:0] : prod[63:32];
endfunction

// A zero divisor gives all ones as quotient and the dividend as remainder.
// Signed overflow gives the dividend as quotient and zero as remainder.
function automatic logic [31:0] division_word(
    input mdu_pkg::md_op_e op,
    input logic [31:0]     a,
    input logic [31:0]     b
);
    logic signed [63:0] sa, sb, sq, sr;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (b == 32'd0) begin
        return (op inside {mdu_pkg::md_div, mdu_pkg::md_divu}) ? 32'hffff_ffff : a;
    end
    if (op inside {mdu_pkg::md_div, mdu_pkg::md_rem} && a == 32'h8000_0000 &&
        b == 32'hffff_ffff) begin
        return (op == mdu_pkg::md_div) ? a : 32'd0;
    end
    sq = sa / sb;
    sr = sa % sb;
    case (op)
        mdu_pkg::md_div:  return sq[31:0];
        mdu_pkg::md_rem:  return sr[31:0];
        mdu_pkg::md_divu: return a / b;
        default:          return a % b;
    endcase
endfunction

function automatic logic [31:0] expected_result(
    input mdu_pkg::md_op_e op,
    input logic [31:0]     a,
    input logic [31:0]     b
);
    if (op inside {mdu_pkg::md_mul, mdu_pkg::md_mulh, mdu_pkg::md_mulhsu,
                   mdu_pkg::md_mulhu}) begin
        return product_word(op, a, b);
    end
    if (op inside {mdu_pkg::md_div, mdu_pkg::md_divu, mdu_pkg::md_rem,
                   mdu_pkg::md_remu}) begin
        return division_word(op, a, b);
    end
    return 32'd0;
endfunction

`endif

//--- tb_mdu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mdu;

    localparam int timeout_cycles = 64;

    logic                     clk;
    logic                     reset;
    logic [mdu_pkg::xlen-1:0] first_operand;
    logic [mdu_pkg::xlen-1:0] second_operand;
    mdu_pkg::md_op_e          operation;
    logic                     hold;
    logic [mdu_pkg::xlen-1:0] result;

    integer seed = 70842;
    int     test_errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    `include "tb_mdu_model.svh"

    mdu UUT (
        .clk              (clk),
        .reset            (reset),
        .first_operand_i  (first_operand),
        .second_operand_i (second_operand),
        .operation_i      (operation),
        .hold_o           (hold),
        .result_o         (result)
    );

    always #5 clk = ~clk;

    // Stall length from the first cycle an operation is presented.
    function automatic int expected_latency(
        input mdu_pkg::md_op_e op,
        input logic [31:0]     a,
        input logic [31:0]     b
    );
        if (op inside {mdu_pkg::md_mul, mdu_pkg::md_mulh, mdu_pkg::md_mulhsu,
                       mdu_pkg::md_mulhu}) begin
            return 5;
        end
        if (b == 32'd0 || b == 32'd1) begin
            return 1;
        end
        if (op inside {mdu_pkg::md_divu, mdu_pkg::md_remu}) begin
            return 33;
        end
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return 1;
        end
        return 34;
    endfunction

    // Indices 0 to 3 are the multiplies and 4 to 7 the divides.
    function automatic mdu_pkg::md_op_e op_from_index(input int idx);
        case (idx & 7)
            0:       return mdu_pkg::md_mul;
            1:       return mdu_pkg::md_mulh;
            2:       return mdu_pkg::md_mulhsu;
            3:       return mdu_pkg::md_mulhu;
            4:       return mdu_pkg::md_div;
            5:       return mdu_pkg::md_divu;
            6:       return mdu_pkg::md_rem;
            default: return mdu_pkg::md_remu;
        endcase
    endfunction

    function automatic logic [31:0] random_divisor();
        logic [31:0] b;
        if ($random(seed) & 1) begin
            b = $random(seed) % 64;
        end else begin
            b = $random(seed);
        end
        return (b == 32'd0 || b == 32'd1) ? 32'd7 : b;
    endfunction

    task automatic present(input mdu_pkg::md_op_e op, input logic [31:0] a,
                           input logic [31:0] b);
        @(posedge clk);
        #1;
        operation      = op;
        first_operand  = a;
        second_operand = b;
    endtask

    task automatic run_op(input mdu_pkg::md_op_e op, input logic [31:0] a,
                          input logic [31:0] b);
        logic [31:0] expected;
        int          latency;
        int          cycles;
        expected = expected_result(op, a, b);
        latency  = expected_latency(op, a, b);
        present(op, a, b);
        @(negedge clk);
        if (hold !== 1'b1) begin
            $display("[ERROR] %0t hold_o expected 1 actual %b (first cycle of %s)", $time,
                     hold, op.name());
            test_errors++;
        end
        cycles = 0;
        while (hold === 1'b1 && cycles < timeout_cycles) begin
            cycles++;
            @(negedge clk);
        end
        if (hold === 1'b1) begin
            $display("%0t: hold_o never fell within %0d cycles for %s", $time,
                     timeout_cycles, op.name());
            test_errors++;
        end else begin
            if (cycles != latency) begin
                $display("%0t: %s stalled for %0d cycles instead of %0d", $time, op.name(),
                         cycles, latency);
                test_errors++;
            end
            if (result !== expected) begin
                $display("[ERROR] %0t result_o expected %h actual %h (%s %h %h)", $time,
                         expected, result, op.name(), a, b);
                test_errors++;
            end
        end
        present(mdu_pkg::md_none, a, b);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("ok    %s", name);
        end else begin
            tests_failed++;
            $display("fail  %s with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        first_operand  = '0;
        second_operand = '0;
        operation      = mdu_pkg::md_none;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        if (hold !== 1'b0) begin
            $display("[ERROR] %0t hold_o expected 0 actual %b", $time, hold);
            test_errors++;
        end
        if (result !== 32'd0) begin
            $display("[ERROR] %0t result_o expected %h actual %h", $time, 32'd0, result);
            test_errors++;
        end
        finish_test("idle after reset");

        repeat (200) run_op(op_from_index($random(seed) & 3), $random(seed), $random(seed));
        finish_test("random multiplies");

        repeat (200) run_op(op_from_index(4 + ($random(seed) & 3)), $random(seed),
                            random_divisor());
        finish_test("random divides");

        for (int k = 4; k < 8; k++) begin
            for (int d = 0; d < 2; d++) begin
                repeat (3) run_op(op_from_index(k), $random(seed), d);
            end
        end
        finish_test("divide by zero and by one");

        for (int k = 4; k < 8; k++) begin
            run_op(op_from_index(k), 32'h8000_0000, 32'hffff_ffff);
        end
        finish_test("signed overflow");

        repeat (100) run_op(op_from_index($random(seed)), $random(seed), random_divisor());
        finish_test("mixed back-to-back");

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
mdu_pkg.sv
md_req_if.sv
div.sv
mul.sv
mdu.sv
tb_mdu.sv
